// File: issue_pkg.sv
package issue_pkg;

    // Instruction bit count and unit control bit count
    localparam int ILEN       = 32;
    localparam int EU_CTL_LEN = 8;

    // Major opcodes of the supported groups
    localparam logic [6:0] OPC_OP         = 7'b0110011;
    localparam logic [6:0] OPC_OP_32      = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM     = 7'b0010011;
    localparam logic [6:0] OPC_OP_IMM_32  = 7'b0011011;
    localparam logic [6:0] OPC_LOAD       = 7'b0000011;
    localparam logic [6:0] OPC_STORE      = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH     = 7'b1100011;
    localparam logic [6:0] OPC_LUI        = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC      = 7'b0010111;
    localparam logic [6:0] OPC_JAL        = 7'b1101111;
    localparam logic [6:0] OPC_JALR       = 7'b1100111;

    // ALU funct3
    localparam logic [2:0] F3_ADD_SUB     = 3'b000;
    localparam logic [2:0] F3_SLL         = 3'b001;
    localparam logic [2:0] F3_SLT         = 3'b010;
    localparam logic [2:0] F3_SLTU        = 3'b011;
    localparam logic [2:0] F3_XOR         = 3'b100;
    localparam logic [2:0] F3_SRL_SRA     = 3'b101;
    localparam logic [2:0] F3_OR          = 3'b110;
    localparam logic [2:0] F3_AND         = 3'b111;

    // Load and store funct3, shared by both opcodes
    localparam logic [2:0] F3_B           = 3'b000;
    localparam logic [2:0] F3_H           = 3'b001;
    localparam logic [2:0] F3_W           = 3'b010;
    localparam logic [2:0] F3_D           = 3'b011;
    localparam logic [2:0] F3_BU          = 3'b100;
    localparam logic [2:0] F3_HU          = 3'b101;
    localparam logic [2:0] F3_WU          = 3'b110;

    // Branch and jump funct3
    localparam logic [2:0] F3_BEQ         = 3'b000;
    localparam logic [2:0] F3_BNE         = 3'b001;
    localparam logic [2:0] F3_BLT         = 3'b100;
    localparam logic [2:0] F3_BGE         = 3'b101;
    localparam logic [2:0] F3_BLTU        = 3'b110;
    localparam logic [2:0] F3_BGEU        = 3'b111;
    localparam logic [2:0] F3_JALR        = 3'b000;

    // funct7 of the base and the alternate (SUB/SRA) encodings
    localparam logic [6:0] F7_BASE        = 7'b0000000;
    localparam logic [6:0] F7_ALT         = 7'b0100000;

    // RISC-V field layout, the I-type immediate is {funct7, rs2}
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_fields_t;

    typedef enum logic [2:0] {
        EU_NONE, EU_INT_ALU, EU_LOAD_BUFFER, EU_STORE_BUFFER, EU_BRANCH_UNIT
    } issue_eu_t;

    typedef enum logic [3:0] {
        ADD, ADDW, SUB, SUBW, AND, OR, XOR, SLL, SLLW, SRL, SRLW, SRA, SRAW, SLT, SLTU
    } alu_ctl_t;

    typedef enum logic [2:0] {
        BYTE, BYTE_U, HALFWORD, HALFWORD_U, WORD, WORD_U, DOUBLEWORD
    } ls_width_t;

    typedef enum logic [2:0] {
        BEQ, BNE, BLT, BGE, BLTU, BGEU
    } branch_ctl_t;

    typedef enum logic {
        IMM_SEXT, IMM_SHAMT
    } imm_format_t;

    typedef struct packed {
        issue_eu_t             eu;
        logic [EU_CTL_LEN-1:0] eu_ctl;
        logic                  rs1_req;
        logic                  rs2_req;
        logic                  imm_req;
        imm_format_t           imm_format;
        logic                  res_ready;
        logic                  regstat_upd;
    } issue_dec_t;

    // Empty decode, also the value of a decoder without a hit
    localparam issue_dec_t ISSUE_DEC_NONE = '{
        eu:          EU_NONE,
        eu_ctl:      '0,
        rs1_req:     1'b0,
        rs2_req:     1'b0,
        imm_req:     1'b0,
        imm_format:  IMM_SEXT,
        res_ready:   1'b0,
        regstat_upd: 1'b0
    };

endpackage

// File: alu_decoder.sv
`timescale 1ns/1ps

module alu_decoder
    import issue_pkg::*;
(
    input  instr_fields_t fields_i,
    output logic          hit_o,
    output issue_dec_t    dec_o
);

    logic        op_valid;
    logic        r_form;
    logic        shift_arith;
    alu_ctl_t    alu_op;
    imm_format_t imm_fmt;

    // Instruction bit 30 picks SUB and the arithmetic shifts
    assign shift_arith = fields_i.funct7[5];

    always_comb begin
        op_valid = 1'b1;
        r_form   = 1'b0;
        alu_op   = ADD;
        imm_fmt  = IMM_SEXT;
        case (fields_i.opcode)
            OPC_OP: begin
                r_form = 1'b1;
                if (fields_i.funct7 == F7_BASE) begin
                    case (fields_i.funct3)
                        F3_ADD_SUB: alu_op = ADD;
                        F3_SLL:     alu_op = SLL;
                        F3_SLT:     alu_op = SLT;
                        F3_SLTU:    alu_op = SLTU;
                        F3_XOR:     alu_op = XOR;
                        F3_SRL_SRA: alu_op = SRL;
                        F3_OR:      alu_op = OR;
                        F3_AND:     alu_op = AND;
                        default:    op_valid = 1'b0;
                    endcase
                end else if (fields_i.funct7 == F7_ALT) begin
                    case (fields_i.funct3)
                        F3_ADD_SUB: alu_op = SUB;
                        F3_SRL_SRA: alu_op = SRA;
                        default:    op_valid = 1'b0;
                    endcase
                end else begin
                    op_valid = 1'b0;
                end
            end
            // 32-bit register forms, sign-extended result
            OPC_OP_32: begin
                r_form = 1'b1;
                if (fields_i.funct7 == F7_BASE) begin
                    case (fields_i.funct3)
                        F3_ADD_SUB: alu_op = ADDW;
                        F3_SLL:     alu_op = SLLW;
                        F3_SRL_SRA: alu_op = SRLW;
                        default:    op_valid = 1'b0;
                    endcase
                end else if (fields_i.funct7 == F7_ALT) begin
                    case (fields_i.funct3)
                        F3_ADD_SUB: alu_op = SUBW;
                        F3_SRL_SRA: alu_op = SRAW;
                        default:    op_valid = 1'b0;
                    endcase
                end else begin
                    op_valid = 1'b0;
                end
            end
            OPC_OP_IMM: begin
                case (fields_i.funct3)
                    F3_ADD_SUB: alu_op = ADD;
                    F3_SLT:     alu_op = SLT;
                    F3_SLTU:    alu_op = SLTU;
                    F3_XOR:     alu_op = XOR;
                    F3_OR:      alu_op = OR;
                    F3_AND:     alu_op = AND;
                    F3_SLL: begin
                        alu_op  = SLL;
                        imm_fmt = IMM_SHAMT;
                    end
                    default: begin
                        alu_op  = shift_arith ? SRA : SRL;
                        imm_fmt = IMM_SHAMT;
                    end
                endcase
            end
            OPC_OP_IMM_32: begin
                case (fields_i.funct3)
                    F3_ADD_SUB: alu_op = ADDW;
                    F3_SLL: begin
                        alu_op  = SLLW;
                        imm_fmt = IMM_SHAMT;
                    end
                    F3_SRL_SRA: begin
                        alu_op  = shift_arith ? SRAW : SRLW;
                        imm_fmt = IMM_SHAMT;
                    end
                    default: op_valid = 1'b0;
                endcase
            end
            default: op_valid = 1'b0;
        endcase
    end

    always_comb begin
        hit_o = op_valid;
        dec_o = ISSUE_DEC_NONE;
        if (op_valid) begin
            dec_o.eu          = EU_INT_ALU;
            dec_o.eu_ctl      = EU_CTL_LEN'(alu_op);
            dec_o.rs1_req     = 1'b1;
            dec_o.rs2_req     = r_form;
            dec_o.imm_req     = ~r_form;
            dec_o.imm_format  = imm_fmt;
            dec_o.regstat_upd = 1'b1;
        end
    end

endmodule

// File: mem_decoder.sv
`timescale 1ns/1ps

module mem_decoder
    import issue_pkg::*;
(
    input  instr_fields_t fields_i,
    output logic          hit_o,
    output issue_dec_t    dec_o
);

    logic      is_load;
    logic      is_store;
    logic      width_ok;
    ls_width_t width;

    assign is_load  = (fields_i.opcode == OPC_LOAD);
    assign is_store = (fields_i.opcode == OPC_STORE);

    // Unsigned widths exist for loads only
    always_comb begin
        width_ok = 1'b1;
        width    = BYTE;
        case (fields_i.funct3)
            F3_B:    width = BYTE;
            F3_H:    width = HALFWORD;
            F3_W:    width = WORD;
            F3_D:    width = DOUBLEWORD;
            F3_BU: begin
                width    = BYTE_U;
                width_ok = is_load;
            end
            F3_HU: begin
                width    = HALFWORD_U;
                width_ok = is_load;
            end
            F3_WU: begin
                width    = WORD_U;
                width_ok = is_load;
            end
            default: width_ok = 1'b0;
        endcase
    end

    always_comb begin
        hit_o = (is_load | is_store) & width_ok;
        dec_o = ISSUE_DEC_NONE;
        if (hit_o) begin
            dec_o.eu          = is_load ? EU_LOAD_BUFFER : EU_STORE_BUFFER;
            dec_o.eu_ctl      = EU_CTL_LEN'(width);
            dec_o.rs1_req     = 1'b1;
            dec_o.rs2_req     = is_store;
            dec_o.imm_req     = 1'b1;
            dec_o.imm_format  = IMM_SEXT;
            dec_o.regstat_upd = is_load;
        end
    end

endmodule

// File: ctrl_flow_decoder.sv
`timescale 1ns/1ps

module ctrl_flow_decoder
    import issue_pkg::*;
(
    input  instr_fields_t fields_i,
    output logic          hit_o,
    output issue_dec_t    dec_o
);

    logic        is_branch;
    logic        cond_ok;
    logic        is_jalr;
    logic        resolved;
    branch_ctl_t cond;

    assign is_branch = (fields_i.opcode == OPC_BRANCH) & cond_ok;
    assign is_jalr   = (fields_i.opcode == OPC_JALR) & (fields_i.funct3 == F3_JALR);

    // Jumps and upper immediates complete at issue
    assign resolved  = (fields_i.opcode == OPC_LUI) | (fields_i.opcode == OPC_AUIPC)
                     | (fields_i.opcode == OPC_JAL) | is_jalr;

    // funct3 010 and 011 carry no branch
    always_comb begin
        cond_ok = 1'b1;
        cond    = BEQ;
        case (fields_i.funct3)
            F3_BEQ:  cond = BEQ;
            F3_BNE:  cond = BNE;
            F3_BLT:  cond = BLT;
            F3_BGE:  cond = BGE;
            F3_BLTU: cond = BLTU;
            F3_BGEU: cond = BGEU;
            default: cond_ok = 1'b0;
        endcase
    end

    always_comb begin
        hit_o = is_branch | resolved;
        dec_o = ISSUE_DEC_NONE;
        if (is_branch) begin
            dec_o.eu         = EU_BRANCH_UNIT;
            dec_o.eu_ctl     = EU_CTL_LEN'(cond);
            dec_o.rs1_req    = 1'b1;
            dec_o.rs2_req    = 1'b1;
            dec_o.imm_req    = 1'b1;
            dec_o.imm_format = IMM_SEXT;
        end else if (resolved) begin
            // No unit, only JALR reads a base register
            dec_o.rs1_req     = is_jalr;
            dec_o.imm_req     = 1'b1;
            dec_o.imm_format  = IMM_SEXT;
            dec_o.res_ready   = 1'b1;
            dec_o.regstat_upd = 1'b1;
        end
    end

endmodule

// File: issue_select.sv
`timescale 1ns/1ps

module issue_select
    import issue_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       instr_valid_i,
    input  logic       alu_hit_i,
    input  logic       mem_hit_i,
    input  logic       cf_hit_i,
    input  issue_dec_t alu_dec_i,
    input  issue_dec_t mem_dec_i,
    input  issue_dec_t cf_dec_i,
    output logic       issue_valid_o,
    output logic       illegal_o,
    output issue_dec_t issue_o
);

    logic       any_hit;
    issue_dec_t sel_dec;

    // Decoders without a hit drive all zeros, so an OR selects
    assign any_hit = alu_hit_i | mem_hit_i | cf_hit_i;
    assign sel_dec = issue_dec_t'(alu_dec_i | mem_dec_i | cf_dec_i);

    always_ff @(posedge clk_i) begin
        if (reset_i || !instr_valid_i) begin
            issue_valid_o <= 1'b0;
            illegal_o     <= 1'b0;
            issue_o       <= ISSUE_DEC_NONE;
        end else begin
            issue_valid_o <= 1'b1;
            illegal_o     <= ~any_hit;
            issue_o       <= sel_dec;
        end
    end

    // Decoder opcode spaces never overlap
    assert property (@(posedge clk_i) disable iff (reset_i)
        instr_valid_i |-> $onehot0({alu_hit_i, mem_hit_i, cf_hit_i}))
    else $error("issue_select: more than one decoder hit");

    // Illegal word leaves with no unit and nothing to fetch or update
    assert property (@(posedge clk_i) disable iff (reset_i)
        illegal_o |-> issue_valid_o && (issue_o.eu == EU_NONE) && !issue_o.rs1_req
                      && !issue_o.rs2_req && !issue_o.imm_req && !issue_o.regstat_upd)
    else $error("issue_select: illegal instruction with live decode fields");

endmodule

// File: issue_decoder_top.sv
`timescale 1ns/1ps

module issue_decoder_top
    import issue_pkg::*;
(
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic            instr_valid_i,
    input  logic [ILEN-1:0] instr_i,
    output logic            issue_valid_o,
    output logic            illegal_o,
    output issue_dec_t      issue_o
);

    instr_fields_t fields;
    logic          alu_hit;
    logic          mem_hit;
    logic          cf_hit;
    issue_dec_t    alu_dec;
    issue_dec_t    mem_dec;
    issue_dec_t    cf_dec;

    assign fields = instr_fields_t'(instr_i);

    // Three decoders see the same word in parallel
    alu_decoder u_alu_decoder (
        .fields_i (fields),
        .hit_o    (alu_hit),
        .dec_o    (alu_dec)
    );

    mem_decoder u_mem_decoder (
        .fields_i (fields),
        .hit_o    (mem_hit),
        .dec_o    (mem_dec)
    );

    ctrl_flow_decoder u_ctrl_flow_decoder (
        .fields_i (fields),
        .hit_o    (cf_hit),
        .dec_o    (cf_dec)
    );

    issue_select u_issue_select (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .alu_hit_i     (alu_hit),
        .mem_hit_i     (mem_hit),
        .cf_hit_i      (cf_hit),
        .alu_dec_i     (alu_dec),
        .mem_dec_i     (mem_dec),
        .cf_dec_i      (cf_dec),
        .issue_valid_o (issue_valid_o),
        .illegal_o     (illegal_o),
        .issue_o       (issue_o)
    );

endmodule

// File: tb_issue_decoder.sv
`timescale 1ns/1ps

module tb_issue_decoder
    import issue_pkg::*;
();

    localparam int          CLK_PERIOD  = 40;
    localparam int          NUM_RANDOM  = 300;
    localparam logic [31:0] FIELD_MASK  = 32'h01FF_8F80;

    // Opcodes that seed the template list, the last three decode as illegal
    localparam logic [6:0] TPL_OPS [14] = '{
        7'b0110011, 7'b0111011, 7'b0010011, 7'b0011011, 7'b0000011, 7'b0100011,
        7'b1100011, 7'b1100111, 7'b0110111, 7'b0010111, 7'b1101111,
        7'b1110011, 7'b0001111, 7'b0101111
    };
    localparam int N_TEMPLATES = 14 * 3 * 8 + 4;

    // Register-form ALU ops by funct3
    localparam alu_ctl_t R_OPS [8] = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};
    // Load widths by funct3, entry 7 unused
    localparam ls_width_t LD_W [8] = '{
        BYTE, HALFWORD, WORD, DOUBLEWORD, BYTE_U, HALFWORD_U, WORD_U, BYTE
    };

    typedef struct packed {
        logic       illegal;
        issue_dec_t dec;
    } ref_result_t;

    logic        clk_i = 1'b0;
    logic        reset_i;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic        issue_valid_o;
    logic        illegal_o;
    issue_dec_t  issue_o;

    logic [15:0] lfsr;
    logic [31:0] tpl_q [$];
    logic        exp_valid;
    ref_result_t exp_q;

    issue_decoder_top uut (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .issue_valid_o (issue_valid_o),
        .illegal_o     (illegal_o),
        .issue_o       (issue_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        fail_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    function automatic ref_result_t alu_res(input alu_ctl_t op, input logic r_form,
                                            input imm_format_t fmt);
        ref_result_t r;
        r = '0;
        r.dec.eu          = EU_INT_ALU;
        r.dec.eu_ctl      = 8'(op);
        r.dec.rs1_req     = 1'b1;
        r.dec.rs2_req     = r_form;
        r.dec.imm_req     = ~r_form;
        r.dec.imm_format  = fmt;
        r.dec.regstat_upd = 1'b1;
        return r;
    endfunction

    function automatic ref_result_t mem_res(input logic store, input ls_width_t w);
        ref_result_t r;
        r = '0;
        r.dec.eu          = store ? EU_STORE_BUFFER : EU_LOAD_BUFFER;
        r.dec.eu_ctl      = 8'(w);
        r.dec.rs1_req     = 1'b1;
        r.dec.rs2_req     = store;
        r.dec.imm_req     = 1'b1;
        r.dec.regstat_upd = ~store;
        return r;
    endfunction

    function automatic ref_result_t br_res(input branch_ctl_t c);
        ref_result_t r;
        r = '0;
        r.dec.eu      = EU_BRANCH_UNIT;
        r.dec.eu_ctl  = 8'(c);
        r.dec.rs1_req = 1'b1;
        r.dec.rs2_req = 1'b1;
        r.dec.imm_req = 1'b1;
        return r;
    endfunction

    // Jumps and upper immediates resolve at issue without a unit
    function automatic ref_result_t jmp_res(input logic uses_rs1);
        ref_result_t r;
        r = '0;
        r.dec.rs1_req     = uses_rs1;
        r.dec.imm_req     = 1'b1;
        r.dec.res_ready   = 1'b1;
        r.dec.regstat_upd = 1'b1;
        return r;
    endfunction

    function automatic ref_result_t ref_decode(input logic [31:0] w);
        ref_result_t r;
        logic [6:0]  op;
        logic [2:0]  f3;
        logic [6:0]  f7;
        op = w[6:0];
        f3 = w[14:12];
        f7 = w[31:25];
        r  = '0;
        r.illegal = 1'b1;
        case (op)
            7'b0110011: begin
                if (f7 == 7'b0000000)
                    r = alu_res(R_OPS[f3], 1'b1, IMM_SEXT);
                else if ({f7, f3} == 10'b0100000_000)
                    r = alu_res(SUB, 1'b1, IMM_SEXT);
                else if ({f7, f3} == 10'b0100000_101)
                    r = alu_res(SRA, 1'b1, IMM_SEXT);
            end
            7'b0111011: begin
                case ({f7, f3})
                    10'b0000000_000: r = alu_res(ADDW, 1'b1, IMM_SEXT);
                    10'b0000000_001: r = alu_res(SLLW, 1'b1, IMM_SEXT);
                    10'b0000000_101: r = alu_res(SRLW, 1'b1, IMM_SEXT);
                    10'b0100000_000: r = alu_res(SUBW, 1'b1, IMM_SEXT);
                    10'b0100000_101: r = alu_res(SRAW, 1'b1, IMM_SEXT);
                    default: ;
                endcase
            end
            7'b0010011: begin
                if (f3 == 3'b101)
                    r = alu_res(w[30] ? SRA : SRL, 1'b0, IMM_SHAMT);
                else
                    r = alu_res(R_OPS[f3], 1'b0, (f3 == 3'b001) ? IMM_SHAMT : IMM_SEXT);
            end
            7'b0011011: begin
                case (f3)
                    3'b000:  r = alu_res(ADDW, 1'b0, IMM_SEXT);
                    3'b001:  r = alu_res(SLLW, 1'b0, IMM_SHAMT);
                    3'b101:  r = alu_res(w[30] ? SRAW : SRLW, 1'b0, IMM_SHAMT);
                    default: ;
                endcase
            end
            7'b0000011: if (f3 != 3'b111) r = mem_res(1'b0, LD_W[f3]);
            7'b0100011: if (!f3[2]) r = mem_res(1'b1, LD_W[f3]);
            7'b1100011: begin
                case (f3)
                    3'b000:  r = br_res(BEQ);
                    3'b001:  r = br_res(BNE);
                    3'b100:  r = br_res(BLT);
                    3'b101:  r = br_res(BGE);
                    3'b110:  r = br_res(BLTU);
                    3'b111:  r = br_res(BGEU);
                    default: ;
                endcase
            end
            7'b1100111: if (f3 == 3'b000) r = jmp_res(1'b1);
            7'b0110111, 7'b0010111, 7'b1101111: r = jmp_res(1'b0);
            default: ;
        endcase
        return r;
    endfunction

    function automatic logic [5:0] flags_of(input issue_dec_t d);
        return {d.rs1_req, d.rs2_req, d.imm_req, d.imm_format, d.res_ready, d.regstat_upd};
    endfunction

    // Every opcode with three funct7 values and all funct3, then privileged words
    task automatic build_templates();
        logic [6:0] f7s [3];
        f7s = '{7'b0000000, 7'b0100000, 7'b0000001};
        foreach (TPL_OPS[i]) begin
            for (int j = 0; j < 3; j++) begin
                for (int f3 = 0; f3 < 8; f3++) begin
                    tpl_q.push_back({f7s[j], 10'b0, 3'(f3), 5'b0, TPL_OPS[i]});
                end
            end
        end
        tpl_q.push_back(32'h3020_0073);
        tpl_q.push_back(32'h1020_0073);
        tpl_q.push_back(32'h1050_0073);
        tpl_q.push_back(32'h1200_0073);
    endtask

    task automatic drive(input logic valid, input logic [31:0] word);
        @(posedge clk_i);
        instr_valid_i <= valid;
        instr_i       <= word;
    endtask

    // Sometimes a dead cycle with junk on the bus goes first
    task automatic issue_word(input logic [31:0] word);
        logic [31:0] sel;
        logic [31:0] junk;
        take_bits(2, sel);
        if (sel[1:0] == 2'b00) begin
            take_bits(32, junk);
            drive(1'b0, junk);
        end
        drive(1'b1, word);
    endtask

    // Expected outputs, one cycle behind the strobe like the issue register
    always @(posedge clk_i) begin
        if (reset_i || !instr_valid_i) begin
            exp_valid <= 1'b0;
            exp_q     <= '0;
        end else begin
            exp_valid <= 1'b1;
            exp_q     <= ref_decode(instr_i);
        end
    end

    assert property (@(posedge clk_i) disable iff (reset_i) issue_valid_o == exp_valid)
    else report_mismatch("issue_valid_o", 32'($sampled(issue_valid_o)), 32'($sampled(exp_valid)));

    assert property (@(posedge clk_i) disable iff (reset_i) illegal_o == exp_q.illegal)
    else report_mismatch("illegal_o", 32'($sampled(illegal_o)), 32'($sampled(exp_q.illegal)));

    assert property (@(posedge clk_i) disable iff (reset_i) issue_o.eu == exp_q.dec.eu)
    else report_mismatch("issue_o.eu", 32'($sampled(issue_o.eu)), 32'($sampled(exp_q.dec.eu)));

    assert property (@(posedge clk_i) disable iff (reset_i) issue_o.eu_ctl == exp_q.dec.eu_ctl)
    else report_mismatch("issue_o.eu_ctl", 32'($sampled(issue_o.eu_ctl)),
                         32'($sampled(exp_q.dec.eu_ctl)));

    assert property (@(posedge clk_i) disable iff (reset_i)
        flags_of(issue_o) == flags_of(exp_q.dec))
    else report_mismatch("issue_o flags", 32'(flags_of($sampled(issue_o))),
                         32'(flags_of($sampled(exp_q.dec))));

    initial begin
        #((13 + 2 * (N_TEMPLATES + NUM_RANDOM) + 20) * CLK_PERIOD);
        fail_run("watchdog timeout, the run did not finish in time");
    end

    initial begin
        logic [31:0] rnd;
        logic [31:0] word;
        int          idx;
        reset_i       <= 1'b1;
        instr_valid_i <= 1'b0;
        instr_i       <= '0;
        lfsr = 16'd53;
        build_templates();
        repeat (10) @(posedge clk_i);
        reset_i <= 1'b0;
        // Idle cycles show the reset defaults
        repeat (3) @(posedge clk_i);
        for (idx = 0; idx < tpl_q.size(); idx++) begin
            take_bits(32, rnd);
            issue_word(tpl_q[idx] | (rnd & FIELD_MASK));
        end
        repeat (NUM_RANDOM) begin
            take_bits(1, rnd);
            take_bits(32, word);
            if (!rnd[0]) begin
                take_bits(9, rnd);
                idx  = int'(rnd[8:0]) % tpl_q.size();
                word = tpl_q[idx] | (word & FIELD_MASK);
            end
            issue_word(word);
        end
        drive(1'b0, '0);
        repeat (3) @(posedge clk_i);
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: project.f
issue_pkg.sv
alu_decoder.sv
mem_decoder.sv
ctrl_flow_decoder.sv
issue_select.sv
issue_decoder_top.sv
tb_issue_decoder.sv

// File: Makefile
TOP := tb_issue_decoder
SIM := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): project.f $(wildcard *.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f project.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "TEST FAILED" sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
